// File: common/gfxPkg.sv
`include "gfx_macros.svh"

package gfxPkg;

	// 12-bit color word, r in the top nibble.
	typedef struct packed
	{
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb444T;

	// Raster counter position.
	typedef struct packed
	{
		logic [9:0] h;
		logic [9:0] v;
	} scanPosT;

	// Sync levels and display enable of one pixel.
	typedef struct packed
	{
		logic hs;
		logic vs;
		logic de;
	} syncT;

	typedef struct packed
	{
		logic       enable;
		logic [9:0] x;
		logic [9:0] y;
		rgb444T     color;
	} spriteCfgT;

	// Row 0 is the top line, bit 15 the leftmost pixel.
	typedef logic [`SPRITE_SIZE-1:0][`SPRITE_SIZE-1:0] bitmapT;

endpackage

// File: common/gfx_macros.svh
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// CPU port widths.
`define GFX_DATA_BITS 16
`define GFX_ADDR_BITS 12

// ------------------------------
// 640x480 raster, 800x525 total.
// ------------------------------
`define H_VISIBLE 640
`define H_FRONT   16
`define H_SYNC    96
`define H_BACK    48
`define H_TOTAL   (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_VISIBLE 480
`define V_FRONT   10
`define V_SYNC    2
`define V_BACK    33
`define V_TOTAL   (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

`define SPRITE_SIZE 16

// Register map.
`define REG_CTRL      12'h000
`define REG_BG        12'h001
`define REG_SPR_COLOR 12'h002
`define REG_SPR_X     12'h003
`define REG_SPR_Y     12'h004
`define REG_BITMAP    12'h010

`endif

// File: design/gfx.sv
`timescale 1ns/10ps
`include "gfx_macros.svh"

module gfx
(
	input  logic                      CLK,
	input  logic                      rstN,
	input  logic [`GFX_ADDR_BITS-1:0] ADDRESS,
	input  logic [`GFX_DATA_BITS-1:0] DATA_IN,
	input  logic                      WR,
	output logic [`GFX_DATA_BITS-1:0] DATA_OUT,
	output logic                      HS,
	output logic                      VS,
	output logic [3:0]                RR,
	output logic [3:0]                GG,
	output logic [3:0]                BB
);
	import gfxPkg::*;

	scanPosT   pos;
	syncT      sync;
	logic      frameStart;
	spriteCfgT cfg;
	bitmapT    bitmap;
	rgb444T    background;
	logic      spriteHit;
	rgb444T    spriteColor;

	videoTiming timing_i
	(
		.CLK        (CLK),
		.rstN       (rstN),
		.pos        (pos),
		.sync       (sync),
		.frameStart (frameStart)
	);

	gfxRegs regs_i
	(
		.CLK        (CLK),
		.rstN       (rstN),
		.ADDRESS    (ADDRESS),
		.DATA_IN    (DATA_IN),
		.WR         (WR),
		.DATA_OUT   (DATA_OUT),
		.cfg        (cfg),
		.bitmap     (bitmap),
		.background (background)
	);

	spriteEngine sprite_i
	(
		.CLK         (CLK),
		.rstN        (rstN),
		.frameStart  (frameStart),
		.pos         (pos),
		.cfg         (cfg),
		.bitmap      (bitmap),
		.spriteHit   (spriteHit),
		.spriteColor (spriteColor)
	);

	pixelMixer mixer_i
	(
		.CLK         (CLK),
		.rstN        (rstN),
		.spriteHit   (spriteHit),
		.sync        (sync),
		.background  (background),
		.spriteColor (spriteColor),
		.HS          (HS),
		.VS          (VS),
		.RR          (RR),
		.GG          (GG),
		.BB          (BB)
	);

endmodule

// File: design/gfxRegs.sv
`timescale 1ns/10ps
`include "gfx_macros.svh"

module gfxRegs
(
	input  logic                      CLK,
	input  logic                      rstN,
	input  logic [`GFX_ADDR_BITS-1:0] ADDRESS,
	input  logic [`GFX_DATA_BITS-1:0] DATA_IN,
	input  logic                      WR,
	output logic [`GFX_DATA_BITS-1:0] DATA_OUT,
	output gfxPkg::spriteCfgT         cfg,
	output gfxPkg::bitmapT            bitmap,
	output gfxPkg::rgb444T            background
);

	logic                      bitmapSel;
	logic [3:0]                row;
	logic [`GFX_DATA_BITS-1:0] readData;

	// Any address in 0x010..0x01F selects a bitmap row.
	assign bitmapSel = {ADDRESS[`GFX_ADDR_BITS-1:4], 4'h0} == `REG_BITMAP;
	assign row       = ADDRESS[3:0];

	// ------------------------------
	// Write decode
	// ------------------------------
	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			cfg        <= '0;
			background <= '0;
			bitmap     <= '0;
		end
		else if (WR)
		begin
			if (bitmapSel)
				bitmap[row] <= DATA_IN[`SPRITE_SIZE-1:0];
			else
				case (ADDRESS)
					`REG_CTRL:      cfg.enable <= DATA_IN[0];
					`REG_BG:        background <= DATA_IN[11:0];
					`REG_SPR_COLOR: cfg.color  <= DATA_IN[11:0];
					`REG_SPR_X:     cfg.x      <= DATA_IN[9:0];
					`REG_SPR_Y:     cfg.y      <= DATA_IN[9:0];
					default:        ;
				endcase
		end
	end

	// ------------------------------
	// Read path
	// ------------------------------
	always_comb
	begin
		readData = '0;
		if (bitmapSel)
			readData = bitmap[row];
		else
			case (ADDRESS)
				`REG_CTRL:      readData = {{(`GFX_DATA_BITS - 1){1'b0}}, cfg.enable};
				`REG_BG:        readData = {{(`GFX_DATA_BITS - 12){1'b0}}, background};
				`REG_SPR_COLOR: readData = {{(`GFX_DATA_BITS - 12){1'b0}}, cfg.color};
				`REG_SPR_X:     readData = {{(`GFX_DATA_BITS - 10){1'b0}}, cfg.x};
				`REG_SPR_Y:     readData = {{(`GFX_DATA_BITS - 10){1'b0}}, cfg.y};
				default:        readData = '0;
			endcase
	end

	// One cycle read latency.
	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
			DATA_OUT <= '0;
		else
			DATA_OUT <= readData;
	end

endmodule

// File: design/pixelMixer.sv
`timescale 1ns/10ps

module pixelMixer
(
	input  logic           CLK,
	input  logic           rstN,
	input  logic           spriteHit,
	input  gfxPkg::syncT   sync,
	input  gfxPkg::rgb444T background,
	input  gfxPkg::rgb444T spriteColor,
	output logic           HS,
	output logic           VS,
	output logic [3:0]     RR,
	output logic [3:0]     GG,
	output logic [3:0]     BB
);
	import gfxPkg::*;

	rgb444T pixel;

	// Sprite over background, black outside the visible area.
	always_comb
	begin
		if (!sync.de)
			pixel = '0;
		else if (spriteHit)
			pixel = spriteColor;
		else
			pixel = background;
	end

	// Color and syncs registered together.
	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			HS <= 1'b1;
			VS <= 1'b1;
			RR <= '0;
			GG <= '0;
			BB <= '0;
		end
		else
		begin
			HS <= sync.hs;
			VS <= sync.vs;
			RR <= pixel.r;
			GG <= pixel.g;
			BB <= pixel.b;
		end
	end

endmodule

// File: design/videoTiming.sv
`timescale 1ns/10ps
`include "gfx_macros.svh"

module videoTiming
(
	input  logic            CLK,
	input  logic            rstN,
	output gfxPkg::scanPosT pos,
	output gfxPkg::syncT    sync,
	output logic            frameStart
);

	localparam int HSyncStart = `H_VISIBLE + `H_FRONT;
	localparam int HSyncEnd   = HSyncStart + `H_SYNC;
	localparam int VSyncStart = `V_VISIBLE + `V_FRONT;
	localparam int VSyncEnd   = VSyncStart + `V_SYNC;

	// ------------------------------
	// Raster counters
	// ------------------------------
	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			pos.h <= '0;
			pos.v <= '0;
		end
		else if (pos.h == `H_TOTAL - 1)
		begin
			pos.h <= '0;
			if (pos.v == `V_TOTAL - 1)
				pos.v <= '0;
			else
				pos.v <= pos.v + 10'd1;
		end
		else
		begin
			pos.h <= pos.h + 10'd1;
		end
	end

	// ------------------------------
	// Sync and enable decode
	// ------------------------------
	always_comb
	begin
		sync.de = (pos.h < `H_VISIBLE) && (pos.v < `V_VISIBLE);
		// Both syncs active low.
		sync.hs = !((pos.h >= HSyncStart) && (pos.h < HSyncEnd));
		sync.vs = !((pos.v >= VSyncStart) && (pos.v < VSyncEnd));
	end

	// High for the single cycle at the raster origin.
	assign frameStart = (pos.h == 10'd0) && (pos.v == 10'd0);

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module gfxTb -f vlog.f -o gfxSim &&
./obj_dir/gfxSim | tee /dev/stderr | grep -x "Test passed" > /dev/null &&
echo "Simulation PASS" ||
{ echo "Simulation FAIL"; exit 1; }

// File: sprite/spriteEngine.sv
`timescale 1ns/10ps
`include "gfx_macros.svh"

module spriteEngine
(
	input  logic              CLK,
	input  logic              rstN,
	input  logic              frameStart,
	input  gfxPkg::scanPosT   pos,
	input  gfxPkg::spriteCfgT cfg,
	input  gfxPkg::bitmapT    bitmap,
	output logic              spriteHit,
	output gfxPkg::rgb444T    spriteColor
);
	import gfxPkg::*;

	localparam int IdxBits = $clog2(`SPRITE_SIZE);

	spriteCfgT               shadowCfg;
	bitmapT                  shadowBitmap;
	spriteCfgT               activeCfg;
	bitmapT                  activeBitmap;
	logic [9:0]              dx;
	logic [9:0]              dy;
	logic                    inX;
	logic                    inY;
	logic [IdxBits-1:0]      colIdx;
	logic [`SPRITE_SIZE-1:0] rowBits;

	// ------------------------------
	// Frame shadow
	// ------------------------------
	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			shadowCfg    <= '0;
			shadowBitmap <= '0;
		end
		else if (frameStart)
		begin
			shadowCfg    <= cfg;
			shadowBitmap <= bitmap;
		end
	end

	// Settings being latched already apply to pixel (0,0).
	always_comb
	begin
		if (frameStart)
		begin
			activeCfg    = cfg;
			activeBitmap = bitmap;
		end
		else
		begin
			activeCfg    = shadowCfg;
			activeBitmap = shadowBitmap;
		end
	end

	// ------------------------------
	// Hit test
	// ------------------------------
	always_comb
	begin
		dx  = pos.h - activeCfg.x;
		dy  = pos.v - activeCfg.y;
		inX = (pos.h >= activeCfg.x) && (dx < `SPRITE_SIZE);
		inY = (pos.v >= activeCfg.y) && (dy < `SPRITE_SIZE);

		// MSB of the row is the leftmost pixel.
		colIdx  = IdxBits'(`SPRITE_SIZE - 1) - dx[IdxBits-1:0];
		rowBits = activeBitmap[dy[IdxBits-1:0]];

		spriteHit = activeCfg.enable && inX && inY && rowBits[colIdx];
	end

	assign spriteColor = activeCfg.color;

endmodule

// File: tb/gfxTb.sv
`timescale 1ns/10ps
`include "gfx_macros.svh"

module gfxTb;
	import gfxPkg::*;

	localparam int     CyclePeriod = 100;
	localparam int     Seed        = 11;
	localparam int     FramesUsed  = 5;
	// One spare frame beyond the frames that the tests run through.
	localparam longint WatchdogNs  = longint'(FramesUsed + 1) * 800 * 525 * CyclePeriod;
	localparam int     SyncCols [11] = '{640, 641, 654, 655, 656, 657, 750, 751, 752, 753, 799};

	typedef struct packed
	{
		int     frame;
		int     h;
		int     v;
		logic   hs;
		logic   vs;
		rgb444T rgb;
	} entryT;

	logic                      CLK;
	logic                      rstN;
	logic [`GFX_ADDR_BITS-1:0] ADDRESS;
	logic [`GFX_DATA_BITS-1:0] DATA_IN;
	logic                      WR;
	logic [`GFX_DATA_BITS-1:0] DATA_OUT;
	logic                      HS;
	logic                      VS;
	logic [3:0]                RR;
	logic [3:0]                GG;
	logic [3:0]                BB;

	// Raster position and the pixel that the ports show.
	int tbH = 0;
	int tbV = 0;
	int tbFrame = 0;
	int shownH = 0;
	int shownV = 0;
	int shownFrame = 0;
	bit shownValid = 1'b0;

	// Expected sprite state of the frame being tabled.
	int          expEnable;
	int          expX;
	int          expY;
	rgb444T      expColor;
	rgb444T      expBg;
	bitmapT      expBitmap;
	int          newX;
	int          newY;
	int unsigned lcgState = Seed;
	int          passCount = 0;
	int          failCount = 0;
	int          testErrors = 0;
	entryT       stimTable[$];

	gfx gfx_i
	(
		.CLK      (CLK),
		.rstN     (rstN),
		.ADDRESS  (ADDRESS),
		.DATA_IN  (DATA_IN),
		.WR       (WR),
		.DATA_OUT (DATA_OUT),
		.HS       (HS),
		.VS       (VS),
		.RR       (RR),
		.GG       (GG),
		.BB       (BB)
	);

	initial
	begin
		CLK = 1'b0;
		forever #(CyclePeriod / 2) CLK = ~CLK;
	end

	initial
	begin
		#(WatchdogNs);
		$display("TIMEOUT: the raster never reached the awaited pixel in time");
		$display("Test failed");
		$finish;
	end

	// ------------------------------
	// Scan position tracking
	// ------------------------------
	always @(posedge CLK)
	begin
		if (rstN)
		begin
			shownH     <= tbH;
			shownV     <= tbV;
			shownFrame <= tbFrame;
			shownValid <= 1'b1;
			if (tbH == 799)
			begin
				tbH <= 0;
				if (tbV == 524)
				begin
					tbV     <= 0;
					tbFrame <= tbFrame + 1;
				end
				else
					tbV <= tbV + 1;
			end
			else
				tbH <= tbH + 1;
		end
	end

	function automatic int unsigned nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 8;
	endfunction

	function automatic rgb444T expectedColor(input int h, input int v);
		logic [3:0] rowIdx;
		logic [3:0] colIdx;
		rowIdx = 4'(v - expY);
		colIdx = 4'(15 - (h - expX));
		if (h >= 640 || v >= 480)
			return 12'h000;
		if (expEnable != 0 && h >= expX && h < expX + 16 && v >= expY && v < expY + 16)
			if (expBitmap[rowIdx][colIdx])
				return expColor;
		return expBg;
	endfunction

	task automatic addEntry(input int frame, input int h, input int v);
		entryT e;
		e.frame = frame;
		e.h     = h;
		e.v     = v;
		e.hs    = !(h >= 656 && h <= 751);
		e.vs    = !(v >= 490 && v <= 491);
		e.rgb   = expectedColor(h, v);
		stimTable.push_back(e);
	endtask

	// Sprite box with a one-pixel ring around it.
	task automatic addBox(input int frame);
		int h;
		int v;
		for (int dy = -1; dy <= 16; dy++)
			for (int dx = -1; dx <= 16; dx++)
			begin
				h = expX + dx;
				v = expY + dy;
				if (h >= 0 && h < 800 && v >= 0 && v < 525)
					addEntry(frame, h, v);
			end
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
				$time, name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic reportTest(input string name);
		if (testErrors == 0)
		begin
			$display("[PASS] %s", name);
			passCount++;
		end
		else
		begin
			$display("[FAIL] %s with %0d errors", name, testErrors);
			failCount++;
		end
		testErrors = 0;
	endtask

	task automatic waitPixel(input int frame, input int h, input int v);
		do
		begin
			@(negedge CLK);
		end
		while (!(shownValid && shownFrame == frame && shownH == h && shownV == v));
	endtask

	task automatic runTable();
		string tag;
		for (int i = 0; i < stimTable.size(); i++)
		begin
			waitPixel(stimTable[i].frame, stimTable[i].h, stimTable[i].v);
			tag = $sformatf("(%0d,%0d)", stimTable[i].h, stimTable[i].v);
			checkValue({"HS", tag}, int'(stimTable[i].hs), 32'(HS));
			checkValue({"VS", tag}, int'(stimTable[i].vs), 32'(VS));
			checkValue({"RR", tag}, int'(stimTable[i].rgb.r), 32'(RR));
			checkValue({"GG", tag}, int'(stimTable[i].rgb.g), 32'(GG));
			checkValue({"BB", tag}, int'(stimTable[i].rgb.b), 32'(BB));
		end
		stimTable.delete();
	endtask

	// ------------------------------
	// CPU port
	// ------------------------------
	task automatic writeReg(input logic [`GFX_ADDR_BITS-1:0] addr,
		input logic [`GFX_DATA_BITS-1:0] data);
		@(posedge CLK);
		ADDRESS <= addr;
		DATA_IN <= data;
		WR      <= 1'b1;
		@(posedge CLK);
		WR <= 1'b0;
	endtask

	task automatic readCheck(input string name, input logic [`GFX_ADDR_BITS-1:0] addr,
		input int expected);
		@(posedge CLK);
		ADDRESS <= addr;
		WR      <= 1'b0;
		@(posedge CLK);
		@(negedge CLK);
		checkValue(name, expected, 32'(DATA_OUT));
	endtask

	task automatic checkResetState();
		checkValue("HS", 1, 32'(HS));
		checkValue("VS", 1, 32'(VS));
		checkValue("RR", 0, 32'(RR));
		checkValue("GG", 0, 32'(GG));
		checkValue("BB", 0, 32'(BB));
		checkValue("DATA_OUT", 0, 32'(DATA_OUT));
	endtask

	task automatic registerReadback();
		int ctrlVal;
		int bgVal;
		int colorVal;
		int xVal;
		int yVal;
		int rowVal [16];
		ctrlVal  = int'(nextRandom() & 32'hFFFF);
		bgVal    = int'(nextRandom() & 32'hFFFF);
		colorVal = int'(nextRandom() & 32'hFFFF);
		xVal     = int'(nextRandom() & 32'hFFFF);
		yVal     = int'(nextRandom() & 32'hFFFF);
		writeReg(`REG_CTRL, 16'(ctrlVal));
		writeReg(`REG_BG, 16'(bgVal));
		writeReg(`REG_SPR_COLOR, 16'(colorVal));
		writeReg(`REG_SPR_X, 16'(xVal));
		writeReg(`REG_SPR_Y, 16'(yVal));
		for (int i = 0; i < 16; i++)
		begin
			rowVal[i] = int'(nextRandom() & 32'hFFFF);
			writeReg(`REG_BITMAP + 12'(i), 16'(rowVal[i]));
		end
		// Writes to holes in the map must be dropped.
		writeReg(12'h005, 16'hBEEF);
		writeReg(12'h020, 16'h1234);
		readCheck("CTRL", `REG_CTRL, ctrlVal & 32'h1);
		readCheck("BG", `REG_BG, bgVal & 32'hFFF);
		readCheck("SPR_COLOR", `REG_SPR_COLOR, colorVal & 32'hFFF);
		readCheck("SPR_X", `REG_SPR_X, xVal & 32'h3FF);
		readCheck("SPR_Y", `REG_SPR_Y, yVal & 32'h3FF);
		for (int i = 0; i < 16; i++)
			readCheck($sformatf("BITMAP[%0d]", i), `REG_BITMAP + 12'(i), rowVal[i]);
		readCheck("UNUSED 0x005", 12'h005, 0);
		readCheck("UNUSED 0x00F", 12'h00F, 0);
		readCheck("UNUSED 0x020", 12'h020, 0);
		readCheck("UNUSED 0xFFF", 12'hFFF, 0);
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial
	begin
		rstN      = 1'b0;
		ADDRESS   = '0;
		DATA_IN   = '0;
		WR        = 1'b0;
		expEnable = 0;
		expX      = 0;
		expY      = 0;
		expColor  = '0;
		expBg     = '0;
		expBitmap = '0;

		@(posedge CLK);
		@(negedge CLK);
		checkResetState();
		@(posedge CLK);
		rstN <= 1'b1;
		@(negedge CLK);
		checkResetState();
		reportTest("reset state");

		registerReadback();
		reportTest("register readback");

		// Frame 1 runs with the sprite off.
		expBg = 12'(nextRandom());
		writeReg(`REG_CTRL, 16'h0000);
		writeReg(`REG_BG, {4'h0, expBg});
		addEntry(1, 0, 0);
		addEntry(1, 320, 0);
		addEntry(1, 639, 0);
		addEntry(1, 0, 240);
		addEntry(1, 333, 240);
		addEntry(1, 639, 240);
		addEntry(1, 0, 479);
		addEntry(1, 639, 479);
		runTable();
		reportTest("background");

		foreach (SyncCols[i])
			addEntry(1, SyncCols[i], 479);
		addEntry(1, 0, 480);
		addEntry(1, 300, 480);
		for (int v = 488; v <= 493; v++)
		begin
			addEntry(1, 0, v);
			addEntry(1, 700, v);
		end
		addEntry(1, 700, 520);
		runTable();
		reportTest("sync and blanking");

		// Sprite programmed late in frame 1 shows from frame 2.
		expX     = int'(nextRandom() % 600);
		expY     = 64 + int'(nextRandom() % 390);
		expColor = 12'(nextRandom());
		if (expColor == expBg)
			expColor = ~expBg;
		writeReg(`REG_SPR_COLOR, {4'h0, expColor});
		writeReg(`REG_SPR_X, 16'(expX));
		writeReg(`REG_SPR_Y, 16'(expY));
		for (int i = 0; i < 16; i++)
		begin
			expBitmap[i] = 16'(nextRandom());
			writeReg(`REG_BITMAP + 12'(i), expBitmap[i]);
		end
		writeReg(`REG_CTRL, 16'h0001);
		expEnable = 1;
		addBox(2);
		runTable();
		reportTest("sprite placement");

		// Move during frame 3. The old box stays until frame 4.
		newX = (expX + 200) % 600;
		newY = 64 + (expY - 64 + 200) % 390;
		waitPixel(3, 0, 32);
		writeReg(`REG_SPR_X, 16'(newX));
		writeReg(`REG_SPR_Y, 16'(newY));
		addBox(3);
		runTable();
		expX = newX;
		expY = newY;
		addBox(4);
		runTable();
		reportTest("frame-latched update");

		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+common
common/gfxPkg.sv
design/videoTiming.sv
design/gfxRegs.sv
sprite/spriteEngine.sv
design/pixelMixer.sv
design/gfx.sv
tb/gfxTb.sv
